/* rtl/xbar_cfg.svh */
// Two payload words carry one select byte per output, so XBAR_PORTS cannot exceed 16
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// Lane count and lane widths
`define XBAR_PORTS     16
`define XBAR_DATA_W    64
`define XBAR_CTRL_W    8

// Idle lane, every byte a control character
`define XBAR_IDLE_DATA 64'h0707_0707_0707_0707
`define XBAR_IDLE_CTRL 8'hFF

// EtherType of a crosspoint config frame
`define XBAR_CFG_ETYPE 16'h8099

`endif

/* rtl/xbar_pkg.sv */
// Types shared by the crosspoint blocks; sel_t is sized from XBAR_PORTS in the cfg header
`include "xbar_cfg.svh"

package xbar_pkg;

    // One lane word, data and its control byte
    typedef struct packed {
        logic [`XBAR_DATA_W-1:0] data;
        logic [`XBAR_CTRL_W-1:0] ctrl;
    } lane_t;

    // Input lane chosen by one output
    typedef logic [$clog2(`XBAR_PORTS)-1:0] sel_t;

    // Config frame parser
    typedef enum logic [1:0] {
        IDLE,
        WORD_0,
        WORD_1,
        DISCARD
    } cfg_state_e;

endpackage

/* rtl/eth_frame_if.sv */
// Header and realigned payload of one frame; no ready, the receiving side must always accept
`include "xbar_cfg.svh"

interface eth_frame_if;

    // One-cycle pulse, rises together with payload word 0
    logic                    hdr_valid;
    logic [15:0]             eth_type;

    // Payload words, realigned to frame byte 14
    logic                    pay_valid;
    logic [`XBAR_DATA_W-1:0] pay_data;
    logic                    pay_last;

    modport src (
        output hdr_valid,
        output eth_type,
        output pay_valid,
        output pay_data,
        output pay_last
    );

    modport dst (
        input hdr_valid,
        input eth_type,
        input pay_valid,
        input pay_data,
        input pay_last
    );

endinterface

/* rtl/frame_header_rx.sv */
// Whole-word frames only, no tkeep; the last 2 bytes are trailer and frames under 3 words vanish
`include "xbar_cfg.svh"

module frame_header_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_valid,
    input  logic                    cfg_last,
    input  logic [`XBAR_DATA_W-1:0] cfg_data,
    eth_frame_if.src                frm
);

    // 0 and 1 are header words, 2 releases the header, 3 means payload continues
    logic [1:0]  word_cnt;
    // Bytes 6-7 of the previous word, first two bytes of the next payload word
    logic [15:0] carry;

    logic        in_payload;

    // Words 2 and up each complete a payload word
    assign in_payload = word_cnt[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt      <= 2'd0;
            frm.hdr_valid <= 1'b0;
            frm.pay_valid <= 1'b0;
            frm.pay_last  <= 1'b0;
        end else begin
            frm.hdr_valid <= cfg_valid && (word_cnt == 2'd2);
            frm.pay_valid <= cfg_valid && in_payload;
            frm.pay_last  <= cfg_valid && cfg_last && in_payload;
            if (cfg_valid) begin
                // A short frame just restarts the count
                if (cfg_last) begin
                    word_cnt <= 2'd0;
                end else if (word_cnt != 2'd3) begin
                    word_cnt <= word_cnt + 2'd1;
                end
            end
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (cfg_valid) begin
            carry <= cfg_data[63:48];
            // EtherType sits in bytes 4-5 of word 1, high byte first
            if (word_cnt == 2'd1) begin
                frm.eth_type <= {cfg_data[39:32], cfg_data[47:40]};
            end
            if (in_payload) begin
                frm.pay_data <= {cfg_data[47:0], carry};
            end
        end
    end

    // The stream has no idle-cycle markers, a last strobe must come with a word
    a_last_with_valid: assert property (
        @(posedge clk) disable iff (rst) cfg_last |-> cfg_valid
    );

endmodule

/* rtl/cfg_parser.sv */
// Only the low select bits of each payload byte are kept; selects take effect 2 edges after a word
`include "xbar_cfg.svh"

module cfg_parser
    import xbar_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    eth_frame_if.dst frm,
    output sel_t    sel [`XBAR_PORTS]
);

    localparam int HALF = `XBAR_PORTS / 2;
    localparam int SEL_W = $bits(sel_t);

    cfg_state_e              state;
    // State seen by the current payload word, header already applied
    cfg_state_e              state_eff;
    cfg_state_e              state_next;
    logic                    ld_lo;
    logic                    ld_hi;
    logic [`XBAR_DATA_W-1:0] word_q;

    always_comb begin
        state_eff = state;
        // Header and payload word 0 arrive together
        if (state == IDLE && frm.hdr_valid) begin
            if (frm.eth_type == `XBAR_CFG_ETYPE) begin
                state_eff = WORD_0;
            end else begin
                state_eff = DISCARD;
            end
        end

        state_next = state_eff;
        if (frm.pay_valid) begin
            if (frm.pay_last) begin
                state_next = IDLE;
            end else if (state_eff == WORD_0) begin
                state_next = WORD_1;
            end else if (state_eff == WORD_1) begin
                state_next = DISCARD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ld_lo <= 1'b0;
            ld_hi <= 1'b0;
        end else begin
            state <= state_next;
            // A final word is still real data
            ld_lo <= frm.pay_valid && (state_eff == WORD_0);
            ld_hi <= frm.pay_valid && (state_eff == WORD_1);
        end
    end

    always_ff @(posedge clk) begin
        if (frm.pay_valid) begin
            word_q <= frm.pay_data;
        end
    end

    // Select registers, identity after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                sel[i] <= sel_t'(i);
            end
        end else begin
            // Byte i of the word selects for output i of its half
            for (int i = 0; i < HALF; i++) begin
                if (ld_lo) begin
                    sel[i] <= word_q[8*i +: SEL_W];
                end
                if (ld_hi) begin
                    sel[HALF+i] <= word_q[8*i +: SEL_W];
                end
            end
        end
    end

    // Receiver must open every frame with a header
    a_pay_needs_hdr: assert property (
        @(posedge clk) disable iff (rst)
        (state == IDLE && frm.pay_valid) |-> frm.hdr_valid
    );

endmodule

/* rtl/lane_crosspoint.sv */
// One cycle of latency from lane_in and sel to lane_out; outputs idle during reset
`include "xbar_cfg.svh"

module lane_crosspoint
    import xbar_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  lane_t lane_in  [`XBAR_PORTS],
    input  sel_t  sel      [`XBAR_PORTS],
    output lane_t lane_out [`XBAR_PORTS]
);

    localparam lane_t IDLE_LANE = '{data: `XBAR_IDLE_DATA, ctrl: `XBAR_IDLE_CTRL};

    for (genvar i = 0; i < `XBAR_PORTS; i++) begin : g_out
        // Registered mux for output i
        always_ff @(posedge clk) begin
            if (rst) begin
                lane_out[i] <= IDLE_LANE;
            end else begin
                lane_out[i] <= lane_in[sel[i]];
            end
        end

        // Config bytes could name a lane that does not exist if the lane count shrinks
        // An unknown select would pass the range test after the cast to int
        a_sel_range: assert property (
            @(posedge clk) disable iff (rst)
            !$isunknown(sel[i]) && (int'(sel[i]) < `XBAR_PORTS)
        );
    end

endmodule

/* rtl/xbar_switch_top.sv */
// Config stream has no ready and must carry whole-word frames; lane_out lags lane_in by one cycle
`include "xbar_cfg.svh"

module xbar_switch_top
    import xbar_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  lane_t                   lane_in  [`XBAR_PORTS],
    output lane_t                   lane_out [`XBAR_PORTS],
    input  logic                    cfg_valid,
    input  logic                    cfg_last,
    input  logic [`XBAR_DATA_W-1:0] cfg_data
);

    eth_frame_if frm ();

    // Current output selects
    sel_t sel [`XBAR_PORTS];

    frame_header_rx u_header_rx (
        .clk       (clk),
        .rst       (rst),
        .cfg_valid (cfg_valid),
        .cfg_last  (cfg_last),
        .cfg_data  (cfg_data),
        .frm       (frm)
    );

    cfg_parser u_cfg_parser (
        .clk (clk),
        .rst (rst),
        .frm (frm),
        .sel (sel)
    );

    lane_crosspoint u_crosspoint (
        .clk      (clk),
        .rst      (rst),
        .lane_in  (lane_in),
        .sel      (sel),
        .lane_out (lane_out)
    );

endmodule

/* tests/tb_clock_gen.sv */
// Free-running 8 ns clock from time zero; reset is released on a falling edge
module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // High for RESET_CYCLES rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* tests/tb_xbar_checker.sv */
// Sees only the DUT ports; assumes whole-word config frames and one cycle of crosspoint latency
`include "xbar_cfg.svh"

module tb_xbar_checker
    import xbar_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input logic                    cfg_valid,
    input logic                    cfg_last,
    input logic [`XBAR_DATA_W-1:0] cfg_data,
    input lane_t                   lane_in  [`XBAR_PORTS],
    input lane_t                   lane_out [`XBAR_PORTS]
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef sel_t [`XBAR_PORTS-1:0] map_t;

    localparam lane_t IDLE_LANE = '{data: `XBAR_IDLE_DATA, ctrl: `XBAR_IDLE_CTRL};

    int   cycle = 0;
    int   check_count = 0;
    int   error_count = 0;
    // Selects used by the mux at the current edge
    map_t active_map;
    // Selects once every pending update has landed
    map_t sched_map;
    map_t frame_base;
    logic [63:0] frame_words [$];
    int   due_q [$];
    map_t map_q [$];
    lane_t prev_in [`XBAR_PORTS];
    map_t prev_map;
    logic prev_rst;
    bit   have_prev = 1'b0;

    function automatic map_t identity_map();
        map_t m;
        for (int i = 0; i < `XBAR_PORTS; i++) begin
            m[i] = sel_t'(i);
        end
        return m;
    endfunction

    // Byte n of the frame in wire order
    function automatic logic [7:0] frame_byte(input logic [63:0] words [$], input int n);
        logic [63:0] w;
        w = words[n / 8];
        return w[8 * (n % 8) +: 8];
    endfunction

    // Selects after the words of a config frame seen so far
    function automatic map_t decode_frame(input logic [63:0] words [$], input map_t base);
        map_t        m;
        logic [15:0] etype;
        m = base;
        if (words.size() < 3) begin
            return m;
        end
        // Frame bytes 12 and 13, high byte first
        etype = {frame_byte(words, 12), frame_byte(words, 13)};
        if (etype != `XBAR_CFG_ETYPE) begin
            return m;
        end
        // Output o takes frame byte 14 + o once payload word o / 8 is complete
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            if (o / 8 + 2 < words.size()) begin
                m[o] = sel_t'(frame_byte(words, 14 + o));
            end
        end
        return m;
    endfunction

    always @(posedge clk) begin : watch
        lane_t exp;
        cycle++;
        // lane_out now holds what the previous edge registered
        if (have_prev) begin
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                exp = prev_rst ? IDLE_LANE : prev_in[prev_map[i]];
                check_count++;
                if (lane_out[i] !== exp) begin
                    error_count++;
                    $display("error at %0t: lane_out[%0d] expected %h got %h",
                             $time, i, exp, lane_out[i]);
                end
            end
        end
        if (rst) begin
            active_map = identity_map();
            sched_map  = identity_map();
            frame_words.delete();
            due_q.delete();
            map_q.delete();
        end else begin
            while (due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                active_map = map_q.pop_front();
            end
            if (cfg_valid) begin
                if (frame_words.size() == 0) begin
                    frame_base = sched_map;
                end
                frame_words.push_back(cfg_data);
                // Each payload word reaches lane_out 3 edges after its input word
                if (frame_words.size() >= 3) begin
                    sched_map = decode_frame(frame_words, frame_base);
                    due_q.push_back(cycle + 3);
                    map_q.push_back(sched_map);
                end
                if (cfg_last) begin
                    frame_words.delete();
                end
            end
        end
        prev_in   = lane_in;
        prev_map  = active_map;
        prev_rst  = rst;
        have_prev = 1'b1;
    end

endmodule

/* tests/tb_xbar_switch.sv */
// Lane data is random from a fixed seed; config frames are whole words with a 2-byte trailer
`include "xbar_cfg.svh"

module tb_xbar_switch
    import xbar_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef sel_t [`XBAR_PORTS-1:0] map_t;

    // Planned frames, worst-case cycles per frame and idle cycles
    localparam int NUM_FRAMES   = 8;
    localparam int FRAME_CYCLES = 6 * 3;
    localparam int IDLE_CYCLES  = 5 + 20 + 50 + 20 + 20 + 20 + 30;
    localparam int WATCHDOG_NS  = 2 * 8 * (NUM_FRAMES * FRAME_CYCLES + IDLE_CYCLES) + 400;

    logic                    clk;
    logic                    rst;
    logic                    cfg_valid;
    logic                    cfg_last;
    logic [`XBAR_DATA_W-1:0] cfg_data;
    lane_t                   lane_in  [`XBAR_PORTS];
    lane_t                   lane_out [`XBAR_PORTS];

    // Mapping each test intends
    map_t exp_map;
    int   map_errors = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   errors_at_start = 0;

    tb_clock_gen #(.RESET_CYCLES(5)) u_clock (.clk(clk), .rst(rst));

    xbar_switch_top dut (
        .clk       (clk),
        .rst       (rst),
        .lane_in   (lane_in),
        .lane_out  (lane_out),
        .cfg_valid (cfg_valid),
        .cfg_last  (cfg_last),
        .cfg_data  (cfg_data)
    );

    tb_xbar_checker chk (
        .clk       (clk),
        .rst       (rst),
        .cfg_valid (cfg_valid),
        .cfg_last  (cfg_last),
        .cfg_data  (cfg_data),
        .lane_in   (lane_in),
        .lane_out  (lane_out)
    );

    task automatic drive_lanes();
        forever begin
            @(negedge clk);
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                lane_in[i] = {$urandom(), $urandom(), 8'($urandom())};
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            cfg_valid = 1'b0;
            cfg_last  = 1'b0;
            cfg_data  = '0;
        end
    endtask

    function automatic map_t random_perm();
        map_t p;
        sel_t t;
        int   j;
        for (int i = 0; i < `XBAR_PORTS; i++) begin
            p[i] = sel_t'(i);
        end
        for (int i = `XBAR_PORTS - 1; i > 0; i--) begin
            j = $urandom_range(0, i);
            t = p[i];
            p[i] = p[j];
            p[j] = t;
        end
        return p;
    endfunction

    // Random header and filler, one select byte per output from frame byte 14
    task automatic send_frame(input logic [15:0] etype, input map_t perm,
                              input int nwords, input bit gaps);
        logic [7:0]  bytes [$];
        logic [63:0] word;
        for (int b = 0; b < 8 * nwords; b++) begin
            bytes.push_back(8'($urandom()));
        end
        bytes[12] = etype[15:8];
        bytes[13] = etype[7:0];
        for (int i = 0; i < `XBAR_PORTS && 14 + i < 8 * nwords - 2; i++) begin
            bytes[14 + i] = {4'($urandom()), perm[i]};
        end
        for (int k = 0; k < nwords; k++) begin
            for (int b = 0; b < 8; b++) begin
                word[8*b +: 8] = bytes[8*k + b];
            end
            if (gaps) begin
                idle($urandom_range(0, 2));
            end
            @(negedge clk);
            cfg_valid = 1'b1;
            cfg_last  = (k == nwords - 1);
            cfg_data  = word;
        end
        // 3 words carry selects 0-7, a fourth carries 8-15
        if (etype == `XBAR_CFG_ETYPE && nwords >= 3) begin
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                if (i < 8 || nwords >= 4) begin
                    exp_map[i] = perm[i];
                end
            end
        end
    endtask

    task automatic check_mapping();
        if (chk.active_map !== exp_map) begin
            map_errors++;
            $display("error at %0t: select map expected %h got %h",
                     $time, exp_map, chk.active_map);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = chk.error_count + map_errors - errors_at_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
        errors_at_start = chk.error_count + map_errors;
    endtask

    initial begin
        void'($urandom(32'h9ddc));
        cfg_valid = 1'b0;
        cfg_last  = 1'b0;
        cfg_data  = '0;
        for (int i = 0; i < `XBAR_PORTS; i++) begin
            lane_in[i] = {$urandom(), $urandom(), 8'($urandom())};
            exp_map[i] = sel_t'(i);
        end
        fork
            drive_lanes();
        join_none

        wait (rst === 1'b0);
        idle(20);
        check_mapping();
        finish_test("reset_identity");

        send_frame(`XBAR_CFG_ETYPE, random_perm(), 5, 1'b0);
        idle(50);
        check_mapping();
        finish_test("remap_all");

        send_frame(16'h0800, random_perm(), 5, 1'b0);
        idle(20);
        check_mapping();
        finish_test("other_ethertype");

        send_frame(`XBAR_CFG_ETYPE, random_perm(), 3, 1'b0);
        idle(20);
        check_mapping();
        send_frame(`XBAR_CFG_ETYPE, random_perm(), 2, 1'b0);
        idle(20);
        check_mapping();
        finish_test("short_frames");

        // Second and third frames start right after the last word of the one before
        send_frame(`XBAR_CFG_ETYPE, random_perm(), 6, 1'b1);
        send_frame(`XBAR_CFG_ETYPE, random_perm(), 4, 1'b0);
        send_frame(`XBAR_CFG_ETYPE, random_perm(), 3, 1'b0);
        send_frame(16'h86DD, random_perm(), 4, 1'b1);
        idle(30);
        check_mapping();
        finish_test("back_to_back");

        $display("tests: %0d ok, %0d failed; lane checks: %0d, errors: %0d",
                 tests_passed, tests_failed, chk.check_count, chk.error_count + map_errors);
        if (tests_failed == 0 && chk.error_count == 0 && map_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/xbar_pkg.sv
rtl/eth_frame_if.sv
rtl/frame_header_rx.sv
rtl/cfg_parser.sv
rtl/lane_crosspoint.sv
rtl/xbar_switch_top.sv
tests/tb_clock_gen.sv
tests/tb_xbar_checker.sv
tests/tb_xbar_switch.sv

/* Bender.yml */
package:
  name: xbar_switch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/xbar_pkg.sv
      - rtl/eth_frame_if.sv
      - rtl/frame_header_rx.sv
      - rtl/cfg_parser.sv
      - rtl/lane_crosspoint.sv
      - rtl/xbar_switch_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_xbar_checker.sv
      - tests/tb_xbar_switch.sv
